/* Makefile */
VERILATOR  = verilator
TOP        = tb_image_dma
RTL_TOP    = image_dma_top
FILELIST   = src.f
LINT_FLAGS = --lint-only -Wall
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
RUN_FLAGS  = +verilator+error+limit+100
OBJ_DIR    = obj_dir
LOG        = sim.log
RTL_FILES  = $(shell grep '^source/' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* source/axi_read_engine.sv */
`timescale 1ns/1ps

module axi_read_engine (
  input  logic                         clk,
  input  logic                         xrst,
  dma_cmd_if.eng                       cmd,
  output logic [dma_pkg::BWIDTH-1:0]   araddr,
  output logic [7:0]                   arlen,
  output logic                         arvalid,
  input  logic                         arready,
  input  logic [dma_pkg::BWIDTH-1:0]   rdata,
  input  logic [1:0]                   rresp,
  input  logic                         rlast,
  input  logic                         rvalid,
  output logic                         rready,
  output logic                         buf_we,
  output logic [dma_pkg::WORDSIZE-1:0] buf_waddr,
  output logic [dma_pkg::BWIDTH-1:0]   buf_wdata
);
  import dma_pkg::*;

  logic                busy;
  logic                rnext;
  logic [WORDSIZE-1:0] wptr;

  assign rnext        = rvalid && rready;
  assign rready       = busy;
  assign cmd.busy     = busy;
  // slverr or decerr on any beat
  assign cmd.resp_err = rnext && rresp >= 2'b10;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      busy <= 1'b0;
    end else if (cmd.start) begin
      busy <= 1'b1;
    end else if (rnext && rlast) begin
      busy <= 1'b0;
    end
  end

  // ====================================================================
  // address channel
  // ====================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      arvalid <= 1'b0;
    end else if (cmd.start) begin
      arvalid <= 1'b1;
    end else if (arready) begin
      arvalid <= 1'b0;
    end
  end

  // single incr burst, arlen is beats minus one
  always_ff @(posedge clk) begin
    if (cmd.start) begin
      araddr <= BWIDTH'(cmd.base);
      arlen  <= 8'(cmd.len - 1'b1);
    end
  end

  // ====================================================================
  // data channel into the buffer
  // ====================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      buf_we <= 1'b0;
    end else begin
      buf_we <= rnext;
    end
  end

  always_ff @(posedge clk) begin
    if (rnext) begin
      buf_wdata <= rdata;
    end
  end

  // word pointer moves after each buffer write
  always_ff @(posedge clk) begin
    if (!xrst) begin
      wptr <= '0;
    end else if (cmd.start) begin
      wptr <= cmd.base[WORDSIZE+LSB-1:LSB];
    end else if (buf_we) begin
      wptr <= wptr + 1'b1;
    end
  end

  assign buf_waddr = wptr;

endmodule

/* source/axi_write_engine.sv */
`timescale 1ns/1ps

module axi_write_engine (
  input  logic                         clk,
  input  logic                         xrst,
  dma_cmd_if.eng                       cmd,
  output logic [dma_pkg::BWIDTH-1:0]   awaddr,
  output logic [7:0]                   awlen,
  output logic                         awvalid,
  input  logic                         awready,
  output logic [dma_pkg::BWIDTH-1:0]   wdata,
  output logic                         wlast,
  output logic                         wvalid,
  input  logic                         wready,
  input  logic [1:0]                   bresp,
  input  logic                         bvalid,
  output logic                         bready,
  output logic [dma_pkg::WORDSIZE-1:0] buf_raddr,
  input  logic [dma_pkg::BWIDTH-1:0]   buf_rdata
);
  import dma_pkg::*;

  logic                busy;
  logic                aw_done;
  logic                w_full;
  logic                skid_valid;
  logic [BWIDTH-1:0]   skid_data;
  logic                rd_pend;
  logic                issue;
  logic                slot_free;
  logic                wnext;
  logic [1:0]          occ;
  logic [WORDSIZE-1:0] rptr;
  logic [LWIDTH-1:0]   rd_left;
  logic [LWIDTH-1:0]   w_left;

  assign cmd.busy     = busy;
  assign cmd.resp_err = bvalid && bready && bresp >= 2'b10;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      busy <= 1'b0;
    end else if (cmd.start) begin
      busy <= 1'b1;
    end else if (bvalid && bready) begin
      busy <= 1'b0;
    end
  end

  // ====================================================================
  // address channel
  // ====================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      awvalid <= 1'b0;
      aw_done <= 1'b0;
    end else if (cmd.start) begin
      awvalid <= 1'b1;
      aw_done <= 1'b0;
    end else if (awvalid && awready) begin
      awvalid <= 1'b0;
      aw_done <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd.start) begin
      awaddr <= BWIDTH'(cmd.base);
      awlen  <= 8'(cmd.len - 1'b1);
    end
  end

  // ====================================================================
  // buffer prefetch
  // ====================================================================

  // words held or in flight once this cycle's beat has left,
  // never more than the output register and the skid register
  assign occ   = 2'(w_full) + 2'(skid_valid) + 2'(rd_pend) - 2'(wnext);
  assign issue = busy && rd_left != '0 && occ < 2'd2;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      rd_pend <= 1'b0;
      rd_left <= '0;
      rptr    <= '0;
    end else if (cmd.start) begin
      rd_pend <= 1'b0;
      rd_left <= cmd.len;
      rptr    <= cmd.base[WORDSIZE+LSB-1:LSB];
    end else begin
      rd_pend <= issue;
      if (issue) begin
        rd_left <= rd_left - 1'b1;
        rptr    <= rptr + 1'b1;
      end
    end
  end

  assign buf_raddr = rptr;

  // ====================================================================
  // data channel
  // ====================================================================

  // beats wait for the address handshake
  assign wvalid    = w_full && aw_done;
  assign wnext     = wvalid && wready;
  assign slot_free = !w_full || wnext;
  assign wlast     = wvalid && w_left == LWIDTH'(1);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      w_full     <= 1'b0;
      skid_valid <= 1'b0;
    end else if (slot_free) begin
      if (skid_valid) begin
        w_full     <= 1'b1;
        skid_valid <= rd_pend;
      end else begin
        w_full <= rd_pend;
      end
    end else if (rd_pend) begin
      // stalled, park the arriving word
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (slot_free && skid_valid) begin
      wdata <= skid_data;
    end else if (slot_free && rd_pend) begin
      wdata <= buf_rdata;
    end
    if (rd_pend && (!slot_free || skid_valid)) begin
      skid_data <= buf_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      w_left <= '0;
    end else if (cmd.start) begin
      w_left <= cmd.len;
    end else if (wnext) begin
      w_left <= w_left - 1'b1;
    end
  end

  // response channel
  always_ff @(posedge clk) begin
    if (!xrst) begin
      bready <= 1'b0;
    end else if (wnext && wlast) begin
      bready <= 1'b1;
    end else if (bvalid) begin
      bready <= 1'b0;
    end
  end

endmodule

/* source/dma_cmd_if.sv */
`timescale 1ns/1ps

interface dma_cmd_if;
  import dma_pkg::*;

  // one-cycle command pulse from the request unit
  logic start;

  // byte address, word index is base >> LSB
  logic [WORDSIZE+LSB-1:0] base;

  // number of beats, never zero when start is high
  logic [LWIDTH-1:0] len;

  // engine status
  logic busy;
  logic resp_err;

  modport req (
    output start,
    output base,
    output len,
    input  busy,
    input  resp_err
  );

  modport eng (
    input  start,
    input  base,
    input  len,
    output busy,
    output resp_err
  );

endinterface

/* source/dma_pkg.sv */
package dma_pkg;

  // ====================================================================
  // data path widths
  // ====================================================================

  // axi data word and buffer word
  localparam int BWIDTH = 32;

  // byte offset bits inside one word
  localparam int LSB = 2;

  // buffer word index, 1024 words
  localparam int WORDSIZE = 10;

  // beat count, holds 1 to 256
  localparam int LWIDTH = 9;

  // ====================================================================
  // host request codes
  // ====================================================================

  // ddr_mode values
  localparam logic DDR_READ  = 1'b0;
  localparam logic DDR_WRITE = 1'b1;

  // bit positions in the err word
  localparam int ERR_ANY   = 0;
  localparam int ERR_READ  = 1;
  localparam int ERR_WRITE = 2;

endpackage

/* source/dma_request.sv */
`timescale 1ns/1ps

module dma_request (
  input  logic                                     clk,
  input  logic                                     xrst,
  input  logic                                     ddr_req,
  input  logic                                     ddr_mode,
  input  logic [dma_pkg::WORDSIZE+dma_pkg::LSB-1:0] ddr_base,
  input  logic [dma_pkg::LWIDTH-1:0]               ddr_len,
  output logic [2:0]                               err,
  output logic                                     busy,
  dma_cmd_if.req                                   cmd_rd,
  dma_cmd_if.req                                   cmd_wr
);
  import dma_pkg::*;

  logic                    req_d;
  logic                    req_edge;
  logic                    rd_accept;
  logic                    wr_accept;
  logic                    rd_start;
  logic                    wr_start;
  logic [WORDSIZE+LSB-1:0] rd_base;
  logic [WORDSIZE+LSB-1:0] wr_base;
  logic [LWIDTH-1:0]       rd_len;
  logic [LWIDTH-1:0]       wr_len;
  logic [2:0]              err_set;

  // ====================================================================
  // request edge and direction decode
  // ====================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      req_d <= 1'b0;
    end else begin
      req_d <= ddr_req;
    end
  end

  assign req_edge = ddr_req && !req_d;

  // zero length or a busy engine drops the request
  assign rd_accept = req_edge && ddr_mode == DDR_READ && ddr_len != '0
                     && !cmd_rd.busy && !rd_start;
  assign wr_accept = req_edge && ddr_mode == DDR_WRITE && ddr_len != '0
                     && !cmd_wr.busy && !wr_start;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      rd_start <= 1'b0;
      wr_start <= 1'b0;
    end else begin
      rd_start <= rd_accept;
      wr_start <= wr_accept;
    end
  end

  // command payload, valid together with start
  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rd_base <= ddr_base;
      rd_len  <= ddr_len;
    end
    if (wr_accept) begin
      wr_base <= ddr_base;
      wr_len  <= ddr_len;
    end
  end

  assign cmd_rd.start = rd_start;
  assign cmd_rd.base  = rd_base;
  assign cmd_rd.len   = rd_len;
  assign cmd_wr.start = wr_start;
  assign cmd_wr.base  = wr_base;
  assign cmd_wr.len   = wr_len;

  // ====================================================================
  // error status
  // ====================================================================

  always_comb begin
    err_set            = '0;
    err_set[ERR_READ]  = cmd_rd.resp_err;
    err_set[ERR_WRITE] = cmd_wr.resp_err;
    err_set[ERR_ANY]   = cmd_rd.resp_err || cmd_wr.resp_err;
  end

  // a new accepted request starts from a clean status,
  // a response failing in that same cycle still shows
  always_ff @(posedge clk) begin
    if (!xrst) begin
      err <= '0;
    end else if (rd_accept || wr_accept) begin
      err <= err_set;
    end else begin
      err <= err | err_set;
    end
  end

  assign busy = cmd_rd.busy || cmd_wr.busy;

endmodule

/* source/image_buffer.sv */
`timescale 1ns/1ps

module image_buffer (
  input  logic                         clk,
  input  logic                         we,
  input  logic [dma_pkg::WORDSIZE-1:0] waddr,
  input  logic [dma_pkg::BWIDTH-1:0]   wdata,
  input  logic [dma_pkg::WORDSIZE-1:0] raddr,
  output logic [dma_pkg::BWIDTH-1:0]   rdata
);
  import dma_pkg::*;

  // one word per index
  logic [BWIDTH-1:0] mem [1 << WORDSIZE];

  // ====================================================================
  // write port
  // ====================================================================

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // ====================================================================
  // read port
  // ====================================================================

  // data follows the address by one cycle
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

/* source/image_dma_top.sv */
`timescale 1ns/1ps

module image_dma_top (
  input  logic                                     clk,
  input  logic                                     xrst,
  // host request
  input  logic                                     ddr_req,
  input  logic                                     ddr_mode,
  input  logic [dma_pkg::WORDSIZE+dma_pkg::LSB-1:0] ddr_base,
  input  logic [dma_pkg::LWIDTH-1:0]               ddr_len,
  output logic [2:0]                               err,
  output logic                                     busy,
  // axi write address and data
  output logic                                     awvalid,
  input  logic                                     awready,
  output logic [dma_pkg::BWIDTH-1:0]               awaddr,
  output logic [7:0]                               awlen,
  output logic                                     wvalid,
  input  logic                                     wready,
  output logic [dma_pkg::BWIDTH-1:0]               wdata,
  output logic                                     wlast,
  // axi write response
  input  logic                                     bvalid,
  output logic                                     bready,
  input  logic [1:0]                               bresp,
  // axi read
  output logic                                     arvalid,
  input  logic                                     arready,
  output logic [dma_pkg::BWIDTH-1:0]               araddr,
  output logic [7:0]                               arlen,
  input  logic                                     rvalid,
  output logic                                     rready,
  input  logic [dma_pkg::BWIDTH-1:0]               rdata,
  input  logic [1:0]                               rresp,
  input  logic                                     rlast
);
  import dma_pkg::*;

  logic                buf_we;
  logic [WORDSIZE-1:0] buf_waddr;
  logic [BWIDTH-1:0]   buf_wdata;
  logic [WORDSIZE-1:0] buf_raddr;
  logic [BWIDTH-1:0]   buf_rdata;

  dma_cmd_if cmd_rd ();
  dma_cmd_if cmd_wr ();

  dma_request dma_request_inst (
    .clk      (clk),
    .xrst     (xrst),
    .ddr_req  (ddr_req),
    .ddr_mode (ddr_mode),
    .ddr_base (ddr_base),
    .ddr_len  (ddr_len),
    .err      (err),
    .busy     (busy),
    .cmd_rd   (cmd_rd.req),
    .cmd_wr   (cmd_wr.req)
  );

  // host to buffer
  axi_read_engine axi_read_engine_inst (
    .clk       (clk),
    .xrst      (xrst),
    .cmd       (cmd_rd.eng),
    .araddr    (araddr),
    .arlen     (arlen),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rlast     (rlast),
    .rvalid    (rvalid),
    .rready    (rready),
    .buf_we    (buf_we),
    .buf_waddr (buf_waddr),
    .buf_wdata (buf_wdata)
  );

  // buffer to host
  axi_write_engine axi_write_engine_inst (
    .clk       (clk),
    .xrst      (xrst),
    .cmd       (cmd_wr.eng),
    .awaddr    (awaddr),
    .awlen     (awlen),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wlast     (wlast),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .buf_raddr (buf_raddr),
    .buf_rdata (buf_rdata)
  );

  image_buffer image_buffer_inst (
    .clk   (clk),
    .we    (buf_we),
    .waddr (buf_waddr),
    .wdata (buf_wdata),
    .raddr (buf_raddr),
    .rdata (buf_rdata)
  );

endmodule

/* src.f */
source/dma_pkg.sv
source/dma_cmd_if.sv
source/dma_request.sv
source/axi_read_engine.sv
source/axi_write_engine.sv
source/image_buffer.sv
source/image_dma_top.sv
tb/axi_mem_model.sv
tb/image_dma_sva.sv
tb/tb_image_dma.sv

/* tb/axi_mem_model.sv */
`timescale 1ns/1ps

module axi_mem_model (
  input  logic        clk,
  input  logic        xrst,
  // host page above the 12-bit dma address per direction
  input  logic [1:0]  rd_page,
  input  logic [1:0]  wr_page,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] awaddr,
  input  logic        wvalid,
  output logic        wready,
  input  logic [31:0] wdata,
  input  logic        wlast,
  output logic        bvalid,
  input  logic        bready,
  output logic [1:0]  bresp,
  input  logic        arvalid,
  output logic        arready,
  input  logic [31:0] araddr,
  input  logic [7:0]  arlen,
  output logic        rvalid,
  input  logic        rready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rlast
);

  integer      seed;
  logic [31:0] golden [4096];
  logic [31:0] mem [4096];
  int          ar_count;
  int          aw_count;
  // full addresses of the last accepted bursts
  logic [31:0] ar_addr_seen;
  logic [31:0] aw_addr_seen;
  logic        ar_go;
  logic        aw_go;
  logic        w_go;
  logic [13:0] r_addr;
  logic [8:0]  r_left;
  logic [13:0] w_addr;
  logic        w_act;
  logic        w_err;

  // slverr window at host bytes 0x3000 to 0x30ff
  function automatic logic in_err_window(input logic [13:0] addr);
    return addr >= 14'h3000 && addr <= 14'h30ff;
  endfunction

  initial begin
    seed   = 82;
    ar_go  = 1'b0;
    aw_go  = 1'b0;
    w_go   = 1'b0;
    rvalid = 1'b0;
    rdata  = '0;
    rresp  = 2'b00;
    rlast  = 1'b0;
    bvalid = 1'b0;
    bresp  = 2'b00;
    for (int i = 0; i < 4096; i++) begin
      golden[i] = {i[15:0], ~i[15:0]} ^ $random(seed);
      mem[i]    = golden[i];
    end
  end

  // ====================================================================
  // random ready stalls
  // ====================================================================

  always @(posedge clk) begin
    ar_go <= $random(seed) % 3 != 0;
    aw_go <= $random(seed) % 3 != 0;
    w_go  <= $random(seed) % 3 != 0;
  end

  // one burst at a time per direction
  assign arready = ar_go && r_left == 9'd0 && !rvalid;
  assign awready = aw_go && !w_act && !bvalid;
  assign wready  = w_go && w_act;

  // ====================================================================
  // read side
  // ====================================================================

  always @(posedge clk) begin
    if (!xrst) begin
      r_left   <= 9'd0;
      rvalid   <= 1'b0;
      ar_count <= 0;
    end else begin
      if (arvalid && arready) begin
        r_addr       <= {rd_page, araddr[11:0]};
        r_left       <= {1'b0, arlen} + 9'd1;
        ar_count     <= ar_count + 1;
        ar_addr_seen <= araddr;
      end
      // a presented beat holds until rready
      if (!rvalid || rready) begin
        if (r_left != 9'd0 && $random(seed) % 3 != 0) begin
          rvalid <= 1'b1;
          rdata  <= mem[r_addr[13:2]];
          rresp  <= in_err_window(r_addr) ? 2'b10 : 2'b00;
          rlast  <= r_left == 9'd1;
          r_addr <= r_addr + 14'd4;
          r_left <= r_left - 9'd1;
        end else begin
          rvalid <= 1'b0;
        end
      end
    end
  end

  // ====================================================================
  // write side
  // ====================================================================

  always @(posedge clk) begin
    if (!xrst) begin
      w_act    <= 1'b0;
      bvalid   <= 1'b0;
      aw_count <= 0;
    end else begin
      if (awvalid && awready) begin
        w_addr       <= {wr_page, awaddr[11:0]};
        w_act        <= 1'b1;
        w_err        <= 1'b0;
        aw_count     <= aw_count + 1;
        aw_addr_seen <= awaddr;
      end
      if (wvalid && wready) begin
        if (in_err_window(w_addr)) begin
          w_err <= 1'b1;
        end else begin
          mem[w_addr[13:2]] <= wdata;
        end
        w_addr <= w_addr + 14'd4;
        if (wlast) begin
          w_act  <= 1'b0;
          bvalid <= 1'b1;
          bresp  <= (w_err || in_err_window(w_addr)) ? 2'b10 : 2'b00;
        end
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

endmodule

/* tb/image_dma_sva.sv */
`timescale 1ns/1ps

module image_dma_sva (
  input logic        clk,
  input logic        xrst,
  input logic [2:0]  err,
  input logic        awvalid,
  input logic        awready,
  input logic [31:0] awaddr,
  input logic [7:0]  awlen,
  input logic        wvalid,
  input logic        wready,
  input logic [31:0] wdata,
  input logic        wlast,
  input logic        arvalid,
  input logic        arready,
  input logic [31:0] araddr,
  input logic [7:0]  arlen
);

  int         fail_count = 0;
  logic [7:0] aw_len_q;
  logic [7:0] w_beats;

  // burst length and accepted beats of the current write
  always_ff @(posedge clk) begin
    if (!xrst) begin
      aw_len_q <= '0;
      w_beats  <= '0;
    end else begin
      if (awvalid && awready) begin
        aw_len_q <= awlen;
      end
      if (wvalid && wready) begin
        w_beats <= wlast ? 8'd0 : w_beats + 8'd1;
      end
    end
  end

  // valid and payload hold until ready
  aw_hold: assert property (@(posedge clk) disable iff (!xrst)
    awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen))
    else begin
      fail_count++;
      $error("awvalid dropped or aw payload changed before awready");
    end

  w_hold: assert property (@(posedge clk) disable iff (!xrst)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
    else begin
      fail_count++;
      $error("wvalid dropped or w payload changed before wready");
    end

  ar_hold: assert property (@(posedge clk) disable iff (!xrst)
    arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
    else begin
      fail_count++;
      $error("arvalid dropped or ar payload changed before arready");
    end

  // wlast only with wvalid and exactly on the final beat
  wlast_with_wvalid: assert property (@(posedge clk) disable iff (!xrst)
    wlast == (wvalid && w_beats == aw_len_q))
    else begin
      fail_count++;
      $error("wlast high without wvalid or off the final beat");
    end

  // status is clean coming out of reset
  err_after_reset: assert property (@(posedge clk) !xrst |=> err == 3'b000)
    else begin
      fail_count++;
      $error("err not zero after reset");
    end

endmodule

bind image_dma_top image_dma_sva image_dma_sva_inst (.*);

/* tb/tb_image_dma.sv */
`timescale 1ns/1ps

module tb_image_dma;
  import dma_pkg::*;

  // beats over all tests set the run limit
  localparam int TOTAL_BEATS    = 32 + 514 + 128 + 28 + 72;
  localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 16 + 2000;
  localparam int PAGE_WORDS     = 1024;

  logic                    clk;
  logic                    xrst;
  logic                    ddr_req;
  logic                    ddr_mode;
  logic [WORDSIZE+LSB-1:0] ddr_base;
  logic [LWIDTH-1:0]       ddr_len;
  logic [2:0]              err;
  logic                    busy;
  logic                    awvalid;
  logic                    awready;
  logic [BWIDTH-1:0]       awaddr;
  logic [7:0]              awlen;
  logic                    wvalid;
  logic                    wready;
  logic [BWIDTH-1:0]       wdata;
  logic                    wlast;
  logic                    bvalid;
  logic                    bready;
  logic [1:0]              bresp;
  logic                    arvalid;
  logic                    arready;
  logic [BWIDTH-1:0]       araddr;
  logic [7:0]              arlen;
  logic                    rvalid;
  logic                    rready;
  logic [BWIDTH-1:0]       rdata;
  logic [1:0]              rresp;
  logic                    rlast;
  logic [1:0]              rd_page;
  logic [1:0]              wr_page;
  int                      cycles = 0;

  image_dma_top image_dma_top_inst (.*);

  axi_mem_model axi_mem_model_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ====================================================================
  // run limit and assertion watch
  // ====================================================================

  always @(posedge clk) begin
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the DUT never went idle", cycles);
      $display(">>> FAIL");
      $fatal(1, "timeout");
    end else if (image_dma_top_inst.image_dma_sva_inst.fail_count != 0) begin
      $display("an assertion on the AXI outputs failed");
      $display(">>> FAIL");
      $fatal(1, "assertion failure");
    end else begin
      cycles <= cycles + 1;
    end
  end

  // ====================================================================
  // helpers
  // ====================================================================

  task automatic check(input string name, input logic [31:0] got,
                       input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // one cycle of ddr_req high with the host page for the model
  task automatic request(input logic mode, input logic [1:0] page,
                         input logic [WORDSIZE+LSB-1:0] base,
                         input logic [LWIDTH-1:0] len);
    @(posedge clk);
    ddr_req  <= 1'b1;
    ddr_mode <= mode;
    ddr_base <= base;
    ddr_len  <= len;
    if (mode == DDR_READ) begin
      rd_page <= page;
    end else begin
      wr_page <= page;
    end
    @(posedge clk);
    ddr_req <= 1'b0;
  endtask

  // busy is up two cycles after the request edge
  task automatic wait_idle;
    repeat (3) @(negedge clk);
    while (busy) begin
      @(negedge clk);
    end
  endtask

  // copied words against the page 0 preload and untouched neighbors
  task automatic compare_copy(input int page, input int word, input int len);
    int dst;
    for (int i = -1; i <= len; i++) begin
      dst = page * PAGE_WORDS + word + i;
      if (i < 0 || i == len) begin
        check($sformatf("host mem[%h]", dst), axi_mem_model_inst.mem[dst],
              axi_mem_model_inst.golden[dst]);
      end else begin
        check($sformatf("host mem[%h]", dst), axi_mem_model_inst.mem[dst],
              axi_mem_model_inst.golden[word + i]);
      end
    end
  endtask

  task automatic round_trip(input logic [1:0] dst_page,
                            input logic [WORDSIZE+LSB-1:0] base,
                            input logic [LWIDTH-1:0] len);
    request(DDR_READ, 2'd0, base, len);
    wait_idle();
    check("araddr", axi_mem_model_inst.ar_addr_seen, 32'(base));
    request(DDR_WRITE, dst_page, base, len);
    wait_idle();
    check("awaddr", axi_mem_model_inst.aw_addr_seen, 32'(base));
    compare_copy(int'(dst_page), int'(base) / 4, int'(len));
    check("err", 32'(err), 32'h0);
  endtask

  // ====================================================================
  // directed tests
  // ====================================================================

  task automatic test_round_trip;
    round_trip(2'd1, 12'h100, 9'd16);
  endtask

  task automatic test_length_limits;
    round_trip(2'd1, 12'h080, 9'd1);
    round_trip(2'd1, 12'h400, 9'd256);
  endtask

  task automatic test_overlap;
    request(DDR_READ, 2'd0, 12'h800, 9'd32);
    wait_idle();
    // load one region while the other drains
    request(DDR_READ, 2'd0, 12'ha00, 9'd32);
    request(DDR_WRITE, 2'd2, 12'h800, 9'd32);
    wait_idle();
    compare_copy(2, 'h200, 32);
    request(DDR_WRITE, 2'd2, 12'ha00, 9'd32);
    wait_idle();
    compare_copy(2, 'h280, 32);
  endtask

  task automatic test_errors;
    request(DDR_READ, 2'd3, 12'h000, 9'd8);
    wait_idle();
    // read and any
    check("err", 32'(err), 32'h3);
    request(DDR_WRITE, 2'd3, 12'h0c0, 9'd16);
    wait_idle();
    // write and any with the read bit cleared by the new request
    check("err", 32'(err), 32'h5);
    request(DDR_READ, 2'd0, 12'h100, 9'd4);
    wait_idle();
    check("err", 32'(err), 32'h0);
  endtask

  task automatic test_dropped;
    int ar_before;
    int aw_before;
    ar_before = axi_mem_model_inst.ar_count;
    aw_before = axi_mem_model_inst.aw_count;
    request(DDR_READ, 2'd0, 12'h300, 9'd0);
    request(DDR_WRITE, 2'd1, 12'h300, 9'd0);
    repeat (20) begin
      @(negedge clk);
      check("busy", 32'(busy), 32'h0);
    end
    check("ar burst count", axi_mem_model_inst.ar_count, ar_before);
    check("aw burst count", axi_mem_model_inst.aw_count, aw_before);
    request(DDR_READ, 2'd0, 12'hc00, 9'd64);
    repeat (3) @(negedge clk);
    check("busy", 32'(busy), 32'h1);
    // second read while the first is running
    request(DDR_READ, 2'd0, 12'hd00, 9'd8);
    wait_idle();
    check("ar burst count", axi_mem_model_inst.ar_count, ar_before + 1);
  endtask

  initial begin
    xrst     = 1'b0;
    ddr_req  = 1'b0;
    ddr_mode = DDR_READ;
    ddr_base = '0;
    ddr_len  = '0;
    rd_page  = 2'd0;
    wr_page  = 2'd0;
    repeat (4) @(posedge clk);
    xrst <= 1'b1;
    test_round_trip();
    test_length_limits();
    test_overlap();
    test_errors();
    test_dropped();
    if (image_dma_top_inst.image_dma_sva_inst.fail_count != 0) begin
      $display("an assertion on the AXI outputs failed");
      $display(">>> FAIL");
      $fatal(1, "assertion failure");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule
